// File: source/uop_pkg.sv
package uop_pkg;

    localparam int ADDR_W    = 32;
    localparam int DATA_W    = 32;
    localparam int SEG_SEL_W = 3;
    localparam int DEST_W    = 8;

    typedef enum logic [1:0] {
        OP_BYTE = 2'd0,
        OP_HALF = 2'd1,
        OP_WORD = 2'd2
    } opsize_e;

    typedef enum logic [1:0] {
        MEM_NONE  = 2'd0,
        MEM_READ  = 2'd1,
        MEM_WRITE = 2'd2
    } mem_rw_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // micro-op as it leaves register read
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic                 valid;
        opsize_e              opsize;
        mem_rw_e              mem_rw;
        logic [ADDR_W-1:0]    base_val;
        logic [ADDR_W-1:0]    index_val;
        logic [1:0]           scale;       // index is shifted left by this
        logic [ADDR_W-1:0]    disp;
        logic [SEG_SEL_W-1:0] seg_sel;
        logic [DATA_W-1:0]    store_data;
        logic [DEST_W-1:0]    dest;
        logic [ADDR_W-1:0]    eip;
    } uop_t;

    // record carried from address generation into the memory stage
    typedef struct packed {
        logic                 valid;
        opsize_e              opsize;
        mem_rw_e              mem_rw;
        logic [ADDR_W-1:0]    addr;        // linear address of the first byte
        logic [ADDR_W-1:0]    addr_end;    // linear address of the last byte
        logic [DATA_W-1:0]    store_data;
        logic [DEST_W-1:0]    dest;
        logic [ADDR_W-1:0]    eip;
        logic                 ie;
        logic [1:0]           ie_type;     // holds a mem_pkg::ie_type_e code
    } rrag_mem_t;

endpackage

// File: source/mem_pkg.sv
package mem_pkg;

    typedef enum logic [1:0] {
        IE_NONE       = 2'd0,
        IE_SEG_LIMIT  = 2'd1,
        IE_MISALIGNED = 2'd2
    } ie_type_e;

    // one entry of the segment table
    typedef struct packed {
        logic [uop_pkg::ADDR_W-1:0] base;
        logic [uop_pkg::ADDR_W-1:0] limit;   // highest legal offset
    } seg_desc_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // one record per micro-op leaving the memory stage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic                       valid;
        logic [uop_pkg::DEST_W-1:0] dest;
        logic [uop_pkg::DATA_W-1:0] data;
        logic [uop_pkg::ADDR_W-1:0] eip;
        logic                       ie;
        ie_type_e                   ie_type;
    } mem_result_t;

endpackage

// File: source/addr_gen.sv
module addr_gen #(
    parameter int NUM_SEGS = 8
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  uop_pkg::uop_t               uop,
    input  logic                        seg_wr_en,
    input  logic [$clog2(NUM_SEGS)-1:0] seg_wr_idx,
    input  mem_pkg::seg_desc_t          seg_wr_desc,
    output uop_pkg::rrag_mem_t          agen
);

    localparam int IDX_W = $clog2(NUM_SEGS);

    mem_pkg::seg_desc_t          seg_tab [NUM_SEGS];
    mem_pkg::seg_desc_t          seg;
    logic [uop_pkg::ADDR_W-1:0]  offset;
    logic [uop_pkg::ADDR_W-1:0]  linear;
    logic [uop_pkg::ADDR_W-1:0]  size_m1;
    logic [uop_pkg::ADDR_W:0]    off_last;
    logic                        is_mem;
    logic                        limit_fault;
    logic                        align_fault;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // segment table, flat segments out of reset
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_SEGS; i++) begin
                seg_tab[i].base  <= '0;
                seg_tab[i].limit <= '1;
            end
        end else if (seg_wr_en) begin
            seg_tab[seg_wr_idx] <= seg_wr_desc;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // address arithmetic and fault checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        seg    = seg_tab[uop.seg_sel[IDX_W-1:0]];
        offset = uop.base_val + (uop.index_val << uop.scale) + uop.disp;
        linear = seg.base + offset;

        case (uop.opsize)
            uop_pkg::OP_BYTE: size_m1 = 32'd0;
            uop_pkg::OP_HALF: size_m1 = 32'd1;
            default:          size_m1 = 32'd3;
        endcase

        // one extra bit so an offset that wraps still counts as past the limit
        off_last    = {1'b0, offset} + {1'b0, size_m1};
        limit_fault = off_last > {1'b0, seg.limit};

        case (uop.opsize)
            uop_pkg::OP_BYTE: align_fault = 1'b0;
            uop_pkg::OP_HALF: align_fault = linear[0];
            default:          align_fault = |linear[1:0];
        endcase

        is_mem = (uop.mem_rw == uop_pkg::MEM_READ) || (uop.mem_rw == uop_pkg::MEM_WRITE);

        agen.valid      = uop.valid;
        agen.opsize     = uop.opsize;
        agen.mem_rw     = uop.mem_rw;
        agen.addr       = linear;
        agen.addr_end   = linear + size_m1;
        agen.store_data = uop.store_data;
        agen.dest       = uop.dest;
        agen.eip        = uop.eip;
        agen.ie         = is_mem && (limit_fault || align_fault);

        if (!agen.ie) begin
            agen.ie_type = mem_pkg::IE_NONE;
        end else if (limit_fault) begin
            agen.ie_type = mem_pkg::IE_SEG_LIMIT;      // limit wins over alignment
        end else begin
            agen.ie_type = mem_pkg::IE_MISALIGNED;
        end
    end

endmodule

// File: source/rrag_mem_latch.sv
module rrag_mem_latch (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               hold,
    input  logic               flush,
    input  uop_pkg::rrag_mem_t d,
    output uop_pkg::rrag_mem_t q
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // RrAg to MEM pipeline register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // only the valid bit is killed, the rest of the record is ignored once
    // valid is low
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            q.valid <= 1'b0;
        end else if (flush) begin
            q.valid <= 1'b0;           // flush beats hold
        end else if (!hold) begin
            q <= d;
        end
    end

endmodule

// File: source/mem_stage.sv
module mem_stage #(
    parameter int DEPTH       = 256,
    parameter int MEM_LATENCY = 3
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  uop_pkg::rrag_mem_t   lat,
    output logic                 stall,
    output mem_pkg::mem_result_t result
);

    localparam int WORD_AW = $clog2(DEPTH);
    localparam int CNT_W   = $clog2(MEM_LATENCY + 1);

    logic [uop_pkg::DATA_W-1:0] mem [DEPTH];

    uop_pkg::rrag_mem_t         cur;
    logic [CNT_W-1:0]           cnt;       // cycles left for cur, 0 when idle
    logic [CNT_W-1:0]           occ;
    logic                       take;
    logic                       finish;
    logic                       lat_access;
    logic                       do_write;
    logic [WORD_AW-1:0]         widx;
    logic [1:0]                 boff;
    logic [3:0]                 be;
    logic [uop_pkg::DATA_W-1:0] wdata;
    logic [uop_pkg::DATA_W-1:0] rshift;
    logic [uop_pkg::DATA_W-1:0] ldata;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // occupancy and back-pressure
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign finish = (cnt == CNT_W'(1));
    assign take   = lat.valid && (cnt <= CNT_W'(1));   // idle or freeing up this cycle
    assign stall  = (cnt > CNT_W'(1));

    assign lat_access = ((lat.mem_rw == uop_pkg::MEM_READ) ||
                         (lat.mem_rw == uop_pkg::MEM_WRITE)) && !lat.ie;
    assign occ        = lat_access ? CNT_W'(MEM_LATENCY) : CNT_W'(1);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // byte lanes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign widx     = cur.addr[WORD_AW+1:2];               // wraps modulo DEPTH words
    assign boff     = cur.addr[1:0];
    assign wdata    = cur.store_data << {boff, 3'b000};
    assign rshift   = mem[widx] >> {boff, 3'b000};
    assign do_write = finish && (cur.mem_rw == uop_pkg::MEM_WRITE) && !cur.ie;

    always_comb begin
        case (cur.opsize)
            uop_pkg::OP_BYTE: begin
                be    = 4'b0001 << boff;
                ldata = {24'd0, rshift[7:0]};
            end
            uop_pkg::OP_HALF: begin
                be    = 4'b0011 << boff;
                ldata = {16'd0, rshift[15:0]};
            end
            default: begin
                be    = 4'b1111;
                ldata = rshift;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (do_write) begin
            for (int i = 0; i < 4; i++) begin
                if (be[i]) begin
                    mem[widx][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stage register and result
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt          <= '0;
            result.valid <= 1'b0;
        end else begin
            if (take) begin
                cnt <= occ;
            end else if (cnt != '0) begin
                cnt <= cnt - 1'b1;
            end
            result.valid <= finish;      // single-cycle pulse
        end

        if (take) begin
            cur <= lat;
        end

        if (finish) begin
            result.dest    <= cur.dest;
            result.eip     <= cur.eip;
            result.ie      <= cur.ie;
            result.ie_type <= mem_pkg::ie_type_e'(cur.ie_type);
            if (cur.ie) begin
                result.data <= '0;
            end else if (cur.mem_rw == uop_pkg::MEM_READ) begin
                result.data <= ldata;
            end else begin
                result.data <= cur.store_data;  // stores and pass-through
            end
        end
    end

endmodule

// File: source/rrag_mem_top.sv
module rrag_mem_top #(
    parameter int NUM_SEGS    = 8,
    parameter int DEPTH       = 256,
    parameter int MEM_LATENCY = 3
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  uop_pkg::uop_t               uop,
    input  logic                        flush,
    input  logic                        seg_wr_en,
    input  logic [$clog2(NUM_SEGS)-1:0] seg_wr_idx,
    input  mem_pkg::seg_desc_t          seg_wr_desc,
    output logic                        stall,
    output mem_pkg::mem_result_t        result
);

    uop_pkg::rrag_mem_t agen;    // combinational output of address generation
    uop_pkg::rrag_mem_t lat;     // latched record seen by the memory stage

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // RrAg
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    addr_gen #(
        .NUM_SEGS    (NUM_SEGS)
    ) u_addr_gen (
        .clk         (clk),
        .rst_n       (rst_n),
        .uop         (uop),
        .seg_wr_en   (seg_wr_en),
        .seg_wr_idx  (seg_wr_idx),
        .seg_wr_desc (seg_wr_desc),
        .agen        (agen)
    );

    // the latch keeps its record for as long as the memory stage is busy
    rrag_mem_latch u_latch (
        .clk   (clk),
        .rst_n (rst_n),
        .hold  (stall),
        .flush (flush),
        .d     (agen),
        .q     (lat)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // MEM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    mem_stage #(
        .DEPTH       (DEPTH),
        .MEM_LATENCY (MEM_LATENCY)
    ) u_mem_stage (
        .clk    (clk),
        .rst_n  (rst_n),
        .lat    (lat),
        .stall  (stall),
        .result (result)
    );

endmodule

// File: test/rrag_mem_checks.sv
module rrag_mem_checks (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 stall,
    input  mem_pkg::mem_result_t result,
    input  mem_pkg::mem_result_t exp_res,   // exp_res.valid says a result is due this cycle
    input  logic                 chk_data,
    input  logic                 exp_stall,
    output logic                 err
);

    initial err = 1'b0;

    task automatic report_value(input string name, input logic [31:0] got,
                                input logic [31:0] want);
        $display("ERROR time=%0t %s got=%h expected=%h", $time, name, got, want);
        err = 1'b1;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // values are set up at the falling edge and sampled here
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(posedge clk) begin
        if (rst_n && !err) begin
            assert (result.valid === exp_res.valid)
                else report_value("result.valid", result.valid, exp_res.valid);
            if (exp_res.valid && result.valid) begin
                assert (result.dest === exp_res.dest)
                    else report_value("result.dest", result.dest, exp_res.dest);
                assert (result.eip === exp_res.eip)
                    else report_value("result.eip", result.eip, exp_res.eip);
                assert (result.ie === exp_res.ie)
                    else report_value("result.ie", result.ie, exp_res.ie);
                assert (result.ie_type === exp_res.ie_type)
                    else report_value("result.ie_type", result.ie_type, exp_res.ie_type);
                if (chk_data) begin
                    assert (result.data === exp_res.data)
                        else report_value("result.data", result.data, exp_res.data);
                end
            end
            // stall is high while the stage holds a micro-op that is not on its last cycle
            assert (stall === exp_stall)
                else report_value("stall", stall, exp_stall);
        end
    end

endmodule

// File: test/rrag_mem_tb.sv
module rrag_mem_tb;

    localparam int NUM_SEGS    = 8;
    localparam int DEPTH       = 256;
    localparam int MEM_LATENCY = 3;
    localparam int N_UOPS      = 145;
    localparam int MAX_EDGES   = N_UOPS * (MEM_LATENCY + 2) + 8 + 200;
    localparam int DRV         = 2;

    typedef struct packed {
        logic [1:0]  rw;
        logic [1:0]  opsize;
        logic [31:0] addr;
        logic [31:0] store_data;
        logic [7:0]  dest;
        logic [31:0] eip;
        logic        ie;
        logic [1:0]  ie_type;
        logic [31:0] cap;     // edge at which the stage takes it
        logic [31:0] due;     // edge at which result.valid rises
    } exp_t;

    logic                 clk;
    logic                 rst_n;
    logic                 flush;
    logic                 seg_wr_en;
    logic [2:0]           seg_wr_idx;
    mem_pkg::seg_desc_t   seg_wr_desc;
    uop_pkg::uop_t        uop;
    logic                 stall;
    mem_pkg::mem_result_t result;
    mem_pkg::mem_result_t exp_res;
    logic                 chk_data;
    logic                 exp_stall;
    logic                 err;
    logic [7:0]           ref_mem [DEPTH*4];
    mem_pkg::seg_desc_t   seg_copy [NUM_SEGS];
    exp_t                 pend_q [$];
    logic [31:0]          lfsr;
    int                   edge_no;
    logic [7:0]           next_dest;

    rrag_mem_top #(
        .NUM_SEGS    (NUM_SEGS),
        .DEPTH       (DEPTH),
        .MEM_LATENCY (MEM_LATENCY)
    ) DUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .uop         (uop),
        .flush       (flush),
        .seg_wr_en   (seg_wr_en),
        .seg_wr_idx  (seg_wr_idx),
        .seg_wr_desc (seg_wr_desc),
        .stall       (stall),
        .result      (result)
    );

    rrag_mem_checks u_checks (
        .clk       (clk),
        .rst_n     (rst_n),
        .stall     (stall),
        .result    (result),
        .exp_res   (exp_res),
        .chk_data  (chk_data),
        .exp_stall (exp_stall),
        .err       (err)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        edge_no <= edge_no + 1;
        if (edge_no >= MAX_EDGES) begin
            $display("timeout: no end of test after %0d clock edges", MAX_EDGES);
            $display("ERRORS FOUND");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    always @(posedge err) begin
        $display("ERRORS FOUND");
        $fatal(1, "run stopped at the first failing check");
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];   // taps 32,22,2,1
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic int size_bytes(input logic [1:0] opsize);
        return (opsize == uop_pkg::OP_BYTE) ? 1 : (opsize == uop_pkg::OP_HALF) ? 2 : 4;
    endfunction

    // splits the wanted offset over base, index and displacement at random
    function automatic uop_pkg::uop_t make_uop(input logic [1:0] rw, input logic [1:0] size,
                                               input logic [2:0] seg, input logic [31:0] offset,
                                               input logic [31:0] data);
        uop_pkg::uop_t u;
        logic [31:0]   idx;
        u            = '0;
        u.valid      = 1'b1;
        u.opsize     = uop_pkg::opsize_e'(size);
        u.mem_rw     = uop_pkg::mem_rw_e'(rw);
        u.scale      = take_bits(2);
        idx          = take_bits(8);
        u.index_val  = idx;
        u.disp       = take_bits(32);
        u.base_val   = offset - (idx << u.scale) - u.disp;
        u.seg_sel    = seg;
        u.store_data = data;
        u.eip        = take_bits(32);
        return u;
    endfunction

    function automatic logic [31:0] load_ref(input logic [31:0] addr, input logic [1:0] opsize);
        logic [31:0] w;
        w = '0;
        for (int i = 0; i < size_bytes(opsize); i++) begin
            w[8*i +: 8] = ref_mem[(addr + i) % (DEPTH * 4)];
        end
        return w;
    endfunction

    task automatic write_seg(input logic [2:0] idx, input logic [31:0] base,
                             input logic [31:0] limit);
        seg_wr_en         = 1'b1;
        seg_wr_idx        = idx;
        seg_wr_desc.base  = base;
        seg_wr_desc.limit = limit;
        @(posedge clk);
        #DRV;
        seg_wr_en         = 1'b0;
        seg_copy[idx]     = seg_wr_desc;
    endtask

    // holds the micro-op until an edge with stall low takes it
    task automatic send(input uop_pkg::uop_t u);
        exp_t        e;
        logic [31:0] offset;
        logic [31:0] linear;
        logic [32:0] last;
        logic        accepted;
        logic        lim;
        logic        mis;
        u.dest    = next_dest;
        next_dest = next_dest + 1;
        uop       = u;
        accepted  = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            accepted = !stall;
            @(posedge clk);
            #DRV;
        end
        uop.valid = 1'b0;
        offset    = u.base_val + (u.index_val << u.scale) + u.disp;
        linear    = seg_copy[u.seg_sel].base + offset;
        last      = {1'b0, offset} + 33'(size_bytes(u.opsize) - 1);
        lim       = last > {1'b0, seg_copy[u.seg_sel].limit};
        mis       = (linear % size_bytes(u.opsize)) != 0;
        e.rw         = u.mem_rw;
        e.opsize     = u.opsize;
        e.addr       = linear;
        e.store_data = u.store_data;
        e.dest       = u.dest;
        e.eip        = u.eip;
        e.ie         = (u.mem_rw != uop_pkg::MEM_NONE) && (lim || mis);
        if (!e.ie) begin
            e.ie_type = mem_pkg::IE_NONE;
        end else if (lim) begin
            e.ie_type = mem_pkg::IE_SEG_LIMIT;    // a limit fault hides misalignment
        end else begin
            e.ie_type = mem_pkg::IE_MISALIGNED;
        end
        e.cap        = edge_no + 1;
        if (pend_q.size() > 0 && pend_q[$].due > e.cap) begin
            e.cap = pend_q[$].due;         // waits in the latch for the stage to free up
        end
        e.due = e.cap + ((u.mem_rw != uop_pkg::MEM_NONE && !e.ie) ? MEM_LATENCY : 1);
        pend_q.push_back(e);
    endtask

    task automatic flush_latch();
        flush = 1'b1;
        @(posedge clk);
        #DRV;
        flush = 1'b0;
        if (pend_q.size() > 0 && pend_q[$].cap > edge_no) begin
            void'(pend_q.pop_back());      // it was still in the latch
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // expected result for the coming check, retires stores into ref_mem
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(negedge clk) begin : expect_result
        exp_t e;
        exp_res  = '0;
        chk_data = 1'b0;
        if (pend_q.size() > 0 && pend_q[0].due == edge_no) begin
            e               = pend_q.pop_front();
            exp_res.valid   = 1'b1;
            exp_res.dest    = e.dest;
            exp_res.eip     = e.eip;
            exp_res.ie      = e.ie;
            exp_res.ie_type = mem_pkg::ie_type_e'(e.ie_type);
            if (e.rw == uop_pkg::MEM_NONE) begin
                exp_res.data = e.store_data;
                chk_data     = 1'b1;
            end else if (!e.ie && e.rw == uop_pkg::MEM_READ) begin
                exp_res.data = load_ref(e.addr, e.opsize);
                chk_data     = 1'b1;
            end else if (!e.ie) begin
                for (int i = 0; i < size_bytes(e.opsize); i++) begin
                    ref_mem[(e.addr + i) % (DEPTH * 4)] = e.store_data[8*i +: 8];
                end
            end
        end
        exp_stall = 1'b0;
        for (int i = 0; i < pend_q.size(); i++) begin
            if (pend_q[i].cap <= edge_no && pend_q[i].due > edge_no + 1) begin
                exp_stall = 1'b1;          // in the stage and not on its last cycle
            end
        end
    end

    initial begin
        logic [1:0] size;
        rst_n       = 1'b0;
        flush       = 1'b0;
        seg_wr_en   = 1'b0;
        seg_wr_idx  = '0;
        seg_wr_desc = '0;
        uop         = '0;
        lfsr        = 32'h5c0b_9e99;
        edge_no     = 0;
        next_dest   = '0;
        exp_stall   = 1'b0;
        exp_res     = '0;
        chk_data    = 1'b0;
        for (int i = 0; i < DEPTH * 4; i++) begin
            ref_mem[i] = 8'h00;
        end
        for (int i = 0; i < NUM_SEGS; i++) begin
            seg_copy[i] = {32'h0, 32'hffff_ffff};
        end
        repeat (8) @(posedge clk);
        #DRV;
        rst_n = 1'b1;
        repeat (4) @(posedge clk);         // quiet after reset
        #DRV;

        for (int w = 0; w < 32; w++) begin
            send(make_uop(uop_pkg::MEM_WRITE, uop_pkg::OP_WORD, 3'd0, w * 4, take_bits(32)));
        end
        write_seg(3'd1, 32'h40, 32'h3f);
        write_seg(3'd2, 32'h20, 32'h0f);
        for (int n = 0; n < 100; n++) begin
            size = take_bits(2);
            if (size == 2'd3) size = uop_pkg::OP_WORD;
            send(make_uop(take_bits(1) ? uop_pkg::MEM_WRITE : uop_pkg::MEM_READ, size,
                          3'(take_bits(1)), take_bits(6) & ~(size_bytes(size) - 1),
                          take_bits(32)));
        end

        // faulting accesses, then reads to show memory is untouched
        send(make_uop(uop_pkg::MEM_WRITE, uop_pkg::OP_WORD, 3'd0, 32'h21, 32'hdead_beef));
        send(make_uop(uop_pkg::MEM_READ, uop_pkg::OP_HALF, 3'd0, 32'h13, 32'h0));
        send(make_uop(uop_pkg::MEM_WRITE, uop_pkg::OP_BYTE, 3'd2, 32'h10, 32'h5a));
        send(make_uop(uop_pkg::MEM_WRITE, uop_pkg::OP_WORD, 3'd2, 32'h0e, 32'h1234_5678));
        send(make_uop(uop_pkg::MEM_READ, uop_pkg::OP_WORD, 3'd2, 32'h0c, 32'h0));
        send(make_uop(uop_pkg::MEM_READ, uop_pkg::OP_WORD, 3'd0, 32'h20, 32'h0));
        send(make_uop(uop_pkg::MEM_READ, uop_pkg::OP_WORD, 3'd0, 32'h2c, 32'h0));
        send(make_uop(uop_pkg::MEM_READ, uop_pkg::OP_WORD, 3'd0, 32'h30, 32'h0));
        send(make_uop(uop_pkg::MEM_NONE, uop_pkg::OP_WORD, 3'd2, 32'hffff_fff3, 32'h77));

        // second micro-op sits in the latch while the first is in the stage
        send(make_uop(uop_pkg::MEM_READ, uop_pkg::OP_WORD, 3'd0, 32'h08, 32'h0));
        send(make_uop(uop_pkg::MEM_WRITE, uop_pkg::OP_WORD, 3'd0, 32'h08, 32'hffff_0000));
        flush_latch();
        send(make_uop(uop_pkg::MEM_READ, uop_pkg::OP_WORD, 3'd0, 32'h08, 32'h0));

        while (pend_q.size() != 0) @(posedge clk);
        #DRV;
        send(make_uop(uop_pkg::MEM_NONE, uop_pkg::OP_BYTE, 3'd1, take_bits(32), take_bits(32)));
        while (pend_q.size() != 0) @(posedge clk);
        repeat (4) @(posedge clk);

        if (err) begin
            $display("ERRORS FOUND");
            $fatal(1, "checks failed");
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule

// File: rrag_mem.f
source/uop_pkg.sv
source/mem_pkg.sv
source/addr_gen.sv
source/rrag_mem_latch.sv
source/mem_stage.sv
source/rrag_mem_top.sv
test/rrag_mem_checks.sv
test/rrag_mem_tb.sv
